/* noc_mesh.f */
+incdir+.
noc_flit_pkg.sv
noc_port_pkg.sv
noc_input_buffer.sv
noc_switch_alloc.sv
noc_output_port.sv
noc_router.sv
noc_mesh_top.sv
noc_mesh_tb.sv

/* noc_mesh_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module noc_mesh_tb;

  localparam int NN    = `NOC_DIM_X * `NOC_DIM_Y;
  localparam int NY    = `NOC_DIM_Y;
  localparam int DEPTH = `NOC_BUF_DEPTH;
  localparam int SINK  = NN - 1;

  logic                clock;
  logic                reset_i;
  logic [NN-1:0]       local_rx_i;
  noc_flit_pkg::flit_t local_data_i [NN];
  logic [NN-1:0]       local_credit_i;
  wire  [NN-1:0]       local_credit_o;
  wire  [NN-1:0]       local_tx_o;
  wire noc_flit_pkg::flit_t local_data_o [NN];

  integer seed = 32'h397b8bec;
  int     err_cnt = 0;
  int     to_cnt = 0;
  logic   reset_q = 1'b0;
  logic   stall = 1'b0;
  logic   quiet_chk = 1'b0;
  int     stall_rx_cnt = 0;

  // per node PE model state
  int inj_credit [NN];
  int injected   [NN];
  int cred_back  [NN];
  int pending    [NN];
  int seq_no     [NN];
  noc_flit_pkg::flit_t send_q [NN][$];

  // scoreboard, one queue per pair indexed src*NN+dst
  noc_flit_pkg::flit_t sb_q     [NN*NN][$];
  noc_flit_pkg::flit_t exp_head [NN*NN];
  logic [NN*NN-1:0]    exp_valid = '0;

  noc_mesh_top dut_i (
    .clock          (clock),
    .reset_i        (reset_i),
    .local_rx_i     (local_rx_i),
    .local_data_i   (local_data_i),
    .local_credit_o (local_credit_o),
    .local_tx_o     (local_tx_o),
    .local_data_o   (local_data_o),
    .local_credit_i (local_credit_i)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    reset_q <= reset_i;
  end

  function automatic void refresh_head(input int p);
    exp_valid[p] = (sb_q[p].size() != 0);
    if (exp_valid[p]) begin
      exp_head[p] = sb_q[p][0];
    end
  endfunction

  // payload carries source node and sequence number
  task automatic queue_flit(input int src, input int dst);
    send_q[src].push_back({2'(src), 14'(seq_no[src]), 8'(dst / NY), 8'(dst % NY)});
    seq_no[src]++;
  endtask

  function automatic int traffic_left();
    int total;
    total = 0;
    for (int n = 0; n < NN; n++) begin
      total += send_q[n].size() + pending[n] + (DEPTH - inj_credit[n]);
    end
    for (int p = 0; p < NN * NN; p++) begin
      total += sb_q[p].size();
    end
    return total;
  endfunction

  task automatic wait_drain(input int limit);
    int cyc;
    cyc = 0;
    while (traffic_left() != 0 && cyc < limit) begin
      @(negedge clock);
      cyc++;
    end
    if (traffic_left() != 0) begin
      to_cnt++;
      $display("timeout: %0d flits or credits still in flight after %0d cycles",
               traffic_left(), limit);
    end
  endtask

  // four PEs: inject against credits, eject and return credits
  always @(posedge clock) begin : pe_model
    noc_flit_pkg::flit_t f;
    int p;
    for (int n = 0; n < NN; n++) begin
      local_rx_i[n]     <= 1'b0;
      local_credit_i[n] <= 1'b0;
      if (!reset_i) begin
        if (local_credit_o[n]) begin
          inj_credit[n]++;
          cred_back[n]++;
        end
        if (local_tx_o[n]) begin
          p = int'(local_data_o[n][31:30]) * NN + n;
          if (sb_q[p].size() != 0) begin
            void'(sb_q[p].pop_front());
          end
          refresh_head(p);
          pending[n]++;
          if (stall && n == SINK) begin
            stall_rx_cnt++;
          end
        end
        // sink credits held back during the stall window
        if (pending[n] != 0 && !(stall && n == SINK)) begin
          local_credit_i[n] <= 1'b1;
          pending[n]--;
        end
        if (inj_credit[n] != 0 && send_q[n].size() != 0 && ($random(seed) % 4) != 0) begin
          f = send_q[n].pop_front();
          p = n * NN + int'(f[15:8]) * NY + int'(f[7:0]);
          sb_q[p].push_back(f);
          refresh_head(p);
          local_rx_i[n]   <= 1'b1;
          local_data_i[n] <= f;
          inj_credit[n]--;
          injected[n]++;
        end
      end
    end
  end

  a_reset_quiet: assert property (
    @(posedge clock) reset_q |-> (local_tx_o == '0 && local_credit_o == '0)
  ) else begin
    err_cnt++;
    $display("FAILED %0t: link activity during or right after reset", $time);
  end

  a_stall_limit: assert property (
    @(posedge clock) disable iff (reset_i) (stall && local_tx_o[SINK]) |-> stall_rx_cnt < DEPTH
  ) else begin
    err_cnt++;
    $display("FAILED %0t: sink got more than %0d flits while stalled", $time, DEPTH);
  end

  for (genvar n = 0; n < NN; n++) begin : g_chk
    localparam logic [15:0] COORD = {8'(n / NY), 8'(n % NY)};

    a_route: assert property (
      @(posedge clock) disable iff (reset_i) local_tx_o[n] |-> local_data_o[n][15:0] == COORD
    ) else begin
      err_cnt++;
      $display("FAILED %0t: node %0d ejected flit %h", $time, n, local_data_o[n]);
    end

    // arrival must match the oldest flit sent on that pair
    a_order: assert property (
      @(posedge clock) disable iff (reset_i) local_tx_o[n] |->
        exp_valid[int'(local_data_o[n][31:30]) * NN + n] &&
        exp_head[int'(local_data_o[n][31:30]) * NN + n] == local_data_o[n]
    ) else begin
      err_cnt++;
      $display("FAILED %0t: node %0d unexpected flit %h", $time, n, local_data_o[n]);
    end

    a_inj_credit: assert property (
      @(posedge clock) disable iff (reset_i) local_credit_o[n] |-> cred_back[n] < injected[n]
    ) else begin
      err_cnt++;
      $display("FAILED %0t: node %0d returned more credits than flits", $time, n);
    end

    a_ej_credit: assert property (
      @(posedge clock) disable iff (reset_i) local_tx_o[n] |-> pending[n] < DEPTH
    ) else begin
      err_cnt++;
      $display("FAILED %0t: node %0d ejected without a free credit", $time, n);
    end

    a_stall_quiet: assert property (
      @(posedge clock) disable iff (reset_i) quiet_chk |-> !local_credit_o[n]
    ) else begin
      err_cnt++;
      $display("FAILED %0t: node %0d got a credit back under back-pressure", $time, n);
    end
  end

  initial begin : main_flow
    int quiet;
    int cyc;
    reset_i        = 1'b1;
    local_rx_i     = '0;
    local_credit_i = '0;
    for (int n = 0; n < NN; n++) begin
      local_data_i[n] = '0;
      inj_credit[n]   = DEPTH;
      injected[n]     = 0;
      cred_back[n]    = 0;
      pending[n]      = 0;
      seq_no[n]       = 0;
    end
    // random traffic, self sends included
    for (int n = 0; n < NN; n++) begin
      for (int k = 0; k < 20; k++) begin
        queue_flit(n, $unsigned($random(seed)) % NN);
      end
    end
    repeat (16) @(posedge clock);
    reset_i <= 1'b0;
    wait_drain(2000);

    // every node floods the sink while its credits are held
    @(negedge clock);
    stall = 1'b1;
    for (int n = 0; n < NN; n++) begin
      for (int k = 0; k < 24; k++) begin
        queue_flit(n, SINK);
      end
    end
    quiet = 0;
    cyc   = 0;
    while (quiet < 20 && cyc < 1000) begin
      @(negedge clock);
      cyc++;
      quiet = (local_credit_o != '0) ? 0 : quiet + 1;
    end
    if (quiet < 20) begin
      to_cnt++;
      $display("timeout: injection credits kept returning while the sink was stalled");
    end
    quiet_chk = 1'b1;
    repeat (40) @(negedge clock);
    quiet_chk = 1'b0;
    stall     = 1'b0;
    wait_drain(3000);

    $display("checks failed: %0d, timeouts: %0d", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* noc_mesh_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module noc_mesh_top (
  input  wire logic                                     clock,
  input  wire logic                                     reset_i,
  input  wire logic [`NOC_DIM_X*`NOC_DIM_Y-1:0]         local_rx_i,
  input  wire noc_flit_pkg::flit_t                      local_data_i [`NOC_DIM_X*`NOC_DIM_Y],
  output wire logic [`NOC_DIM_X*`NOC_DIM_Y-1:0]         local_credit_o,
  output wire logic [`NOC_DIM_X*`NOC_DIM_Y-1:0]         local_tx_o,
  output wire noc_flit_pkg::flit_t                      local_data_o [`NOC_DIM_X*`NOC_DIM_Y],
  input  wire logic [`NOC_DIM_X*`NOC_DIM_Y-1:0]         local_credit_i
);

  localparam int NX = `NOC_DIM_X;
  localparam int NY = `NOC_DIM_Y;
  localparam int NP = noc_port_pkg::NUM_PORTS;

  // per-node link bundles, indexed by port
  wire noc_port_pkg::port_mask_t node_rx      [NX][NY];
  wire noc_port_pkg::port_mask_t node_tx      [NX][NY];
  wire noc_port_pkg::port_mask_t node_cred_in [NX][NY];
  wire noc_port_pkg::port_mask_t node_cred_out[NX][NY];
  wire noc_flit_pkg::flit_t      node_din     [NX][NY][NP];
  wire noc_flit_pkg::flit_t      node_dout    [NX][NY][NP];

  for (genvar x = 0; x < NX; x++) begin : g_x
    for (genvar y = 0; y < NY; y++) begin : g_y
      localparam int N = x * NY + y;

      noc_router #(
        .ROUTER_X(x),
        .ROUTER_Y(y)
      ) router_i (
        .clock    (clock),
        .reset_i  (reset_i),
        .rx_i     (node_rx[x][y]),
        .data_i   (node_din[x][y]),
        .credit_o (node_cred_out[x][y]),
        .tx_o     (node_tx[x][y]),
        .data_o   (node_dout[x][y]),
        .credit_i (node_cred_in[x][y])
      );

      // west side, grounded on the border
      if (x == 0) begin : g_w_gnd
        assign node_rx[x][y][noc_port_pkg::WEST]      = 1'b0;
        assign node_din[x][y][noc_port_pkg::WEST]     = '0;
        assign node_cred_in[x][y][noc_port_pkg::WEST] = 1'b0;
      end else begin : g_w_link
        assign node_rx[x][y][noc_port_pkg::WEST]      = node_tx[x-1][y][noc_port_pkg::EAST];
        assign node_din[x][y][noc_port_pkg::WEST]     = node_dout[x-1][y][noc_port_pkg::EAST];
        assign node_cred_in[x][y][noc_port_pkg::WEST] = node_cred_out[x-1][y][noc_port_pkg::EAST];
      end

      // east side
      if (x == NX - 1) begin : g_e_gnd
        assign node_rx[x][y][noc_port_pkg::EAST]      = 1'b0;
        assign node_din[x][y][noc_port_pkg::EAST]     = '0;
        assign node_cred_in[x][y][noc_port_pkg::EAST] = 1'b0;
      end else begin : g_e_link
        assign node_rx[x][y][noc_port_pkg::EAST]      = node_tx[x+1][y][noc_port_pkg::WEST];
        assign node_din[x][y][noc_port_pkg::EAST]     = node_dout[x+1][y][noc_port_pkg::WEST];
        assign node_cred_in[x][y][noc_port_pkg::EAST] = node_cred_out[x+1][y][noc_port_pkg::WEST];
      end

      // south side
      if (y == 0) begin : g_s_gnd
        assign node_rx[x][y][noc_port_pkg::SOUTH]      = 1'b0;
        assign node_din[x][y][noc_port_pkg::SOUTH]     = '0;
        assign node_cred_in[x][y][noc_port_pkg::SOUTH] = 1'b0;
      end else begin : g_s_link
        assign node_rx[x][y][noc_port_pkg::SOUTH]      = node_tx[x][y-1][noc_port_pkg::NORTH];
        assign node_din[x][y][noc_port_pkg::SOUTH]     = node_dout[x][y-1][noc_port_pkg::NORTH];
        assign node_cred_in[x][y][noc_port_pkg::SOUTH] = node_cred_out[x][y-1][noc_port_pkg::NORTH];
      end

      // north side
      if (y == NY - 1) begin : g_n_gnd
        assign node_rx[x][y][noc_port_pkg::NORTH]      = 1'b0;
        assign node_din[x][y][noc_port_pkg::NORTH]     = '0;
        assign node_cred_in[x][y][noc_port_pkg::NORTH] = 1'b0;
      end else begin : g_n_link
        assign node_rx[x][y][noc_port_pkg::NORTH]      = node_tx[x][y+1][noc_port_pkg::SOUTH];
        assign node_din[x][y][noc_port_pkg::NORTH]     = node_dout[x][y+1][noc_port_pkg::SOUTH];
        assign node_cred_in[x][y][noc_port_pkg::NORTH] = node_cred_out[x][y+1][noc_port_pkg::SOUTH];
      end

      // local port brought out at node index N
      assign node_rx[x][y][noc_port_pkg::LOCAL]      = local_rx_i[N];
      assign node_din[x][y][noc_port_pkg::LOCAL]     = local_data_i[N];
      assign node_cred_in[x][y][noc_port_pkg::LOCAL] = local_credit_i[N];
      assign local_credit_o[N] = node_cred_out[x][y][noc_port_pkg::LOCAL];
      assign local_tx_o[N]     = node_tx[x][y][noc_port_pkg::LOCAL];
      assign local_data_o[N]   = node_dout[x][y][noc_port_pkg::LOCAL];
    end
  end

endmodule

`default_nettype wire

/* noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router #(
  parameter noc_flit_pkg::coord_t ROUTER_X = '0,
  parameter noc_flit_pkg::coord_t ROUTER_Y = '0
) (
  input  wire logic                      clock,
  input  wire logic                      reset_i,
  input  wire noc_port_pkg::port_mask_t  rx_i,
  input  wire noc_flit_pkg::flit_t       data_i [noc_port_pkg::NUM_PORTS],
  output wire noc_port_pkg::port_mask_t  credit_o,
  output wire noc_port_pkg::port_mask_t  tx_o,
  output wire noc_flit_pkg::flit_t       data_o [noc_port_pkg::NUM_PORTS],
  input  wire noc_port_pkg::port_mask_t  credit_i
);

  localparam int NP = noc_port_pkg::NUM_PORTS;

  wire noc_port_pkg::port_mask_t head_valid;
  wire noc_flit_pkg::flit_t      head_flit [NP];
  wire noc_port_pkg::port_mask_t route [NP];
  wire noc_port_pkg::port_mask_t pop;
  wire noc_port_pkg::port_mask_t credit_avail;
  wire noc_port_pkg::port_mask_t out_valid;
  wire noc_flit_pkg::flit_t      out_flit [NP];

  for (genvar p = 0; p < NP; p++) begin : g_port
    // input side
    noc_input_buffer #(
      .ROUTER_X(ROUTER_X),
      .ROUTER_Y(ROUTER_Y)
    ) in_buf_i (
      .clock        (clock),
      .reset_i      (reset_i),
      .rx_i         (rx_i[p]),
      .data_i       (data_i[p]),
      .pop_i        (pop[p]),
      .credit_o     (credit_o[p]),
      .head_valid_o (head_valid[p]),
      .head_flit_o  (head_flit[p]),
      .route_o      (route[p])
    );

    // output side
    noc_output_port out_port_i (
      .clock          (clock),
      .reset_i        (reset_i),
      .out_valid_i    (out_valid[p]),
      .out_flit_i     (out_flit[p]),
      .credit_i       (credit_i[p]),
      .credit_avail_o (credit_avail[p]),
      .tx_o           (tx_o[p]),
      .data_o         (data_o[p])
    );
  end

  noc_switch_alloc alloc_i (
    .clock          (clock),
    .reset_i        (reset_i),
    .head_valid_i   (head_valid),
    .head_flit_i    (head_flit),
    .route_i        (route),
    .credit_avail_i (credit_avail),
    .pop_o          (pop),
    .out_valid_o    (out_valid),
    .out_flit_o     (out_flit)
  );

endmodule

`default_nettype wire

/* noc_output_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module noc_output_port (
  input  wire logic                 clock,
  input  wire logic                 reset_i,
  input  wire logic                 out_valid_i,
  input  wire noc_flit_pkg::flit_t  out_flit_i,
  input  wire logic                 credit_i,
  output logic                      credit_avail_o,
  output logic                      tx_o,
  output noc_flit_pkg::flit_t       data_o
);

  noc_flit_pkg::credit_cnt_t credit_cnt;

  // counter drops at grant time so the next grant already sees it
  always_ff @(posedge clock) begin
    if (reset_i) begin
      credit_cnt <= noc_flit_pkg::credit_cnt_t'(`NOC_BUF_DEPTH);
      tx_o       <= 1'b0;
    end else begin
      case ({out_valid_i, credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      tx_o <= out_valid_i;
    end
  end

  // link data register
  always_ff @(posedge clock) begin
    if (out_valid_i) begin
      data_o <= out_flit_i;
    end
  end

  assign credit_avail_o = (credit_cnt != '0);

  // a flit on the link must have been granted against a free slot downstream
  a_tx_needs_credit: assert property (
    @(posedge clock) disable iff (reset_i) tx_o |-> ($past(credit_cnt) != '0)
  ) else $error("tx launched with zero credit");

endmodule

`default_nettype wire

/* noc_switch_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_switch_alloc (
  input  wire logic                                   clock,
  input  wire logic                                   reset_i,
  input  wire logic [noc_port_pkg::NUM_PORTS-1:0]     head_valid_i,
  input  wire noc_flit_pkg::flit_t                    head_flit_i [noc_port_pkg::NUM_PORTS],
  input  wire noc_port_pkg::port_mask_t               route_i [noc_port_pkg::NUM_PORTS],
  input  wire noc_port_pkg::port_mask_t               credit_avail_i,
  output noc_port_pkg::port_mask_t                    pop_o,
  output noc_port_pkg::port_mask_t                    out_valid_o,
  output noc_flit_pkg::flit_t                         out_flit_o [noc_port_pkg::NUM_PORTS]
);

  localparam int NP    = noc_port_pkg::NUM_PORTS;
  localparam int IDX_W = $clog2(NP);

  // req[o][i] set when input i wants output o
  noc_port_pkg::port_mask_t req    [NP];
  noc_port_pkg::port_mask_t grant  [NP];
  logic [IDX_W-1:0]         rr_ptr [NP];
  logic [IDX_W-1:0]         winner [NP];
  // granted_by[i][o] set when output o took input i
  noc_port_pkg::port_mask_t granted_by [NP];

  always_comb begin
    for (int o = 0; o < NP; o++) begin
      for (int i = 0; i < NP; i++) begin
        req[o][i] = head_valid_i[i] & route_i[i][o];
      end
    end
  end

  // search starts at the pointer and wraps around the five inputs
  always_comb begin
    int idx;
    for (int o = 0; o < NP; o++) begin
      grant[o]  = '0;
      winner[o] = '0;
      for (int k = 0; k < NP; k++) begin
        idx = int'(rr_ptr[o]) + k;
        if (idx >= NP) begin
          idx = idx - NP;
        end
        if (credit_avail_i[o] && req[o][idx] && (grant[o] == '0)) begin
          grant[o][idx] = 1'b1;
          winner[o]     = IDX_W'(idx);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NP; i++) begin
      for (int o = 0; o < NP; o++) begin
        granted_by[i][o] = grant[o][i];
      end
    end
  end

  // crossbar steers each winner and pops the input it took
  always_comb begin
    pop_o = '0;
    for (int o = 0; o < NP; o++) begin
      out_valid_o[o] = |grant[o];
      out_flit_o[o]  = head_flit_i[winner[o]];
      pop_o          = pop_o | grant[o];
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      for (int o = 0; o < NP; o++) begin
        rr_ptr[o] <= '0;
      end
    end else begin
      for (int o = 0; o < NP; o++) begin
        if (out_valid_o[o]) begin
          rr_ptr[o] <= (winner[o] == IDX_W'(NP - 1)) ? '0 : winner[o] + 1'b1;
        end
      end
    end
  end

  // a head flit leaves through one output only
  for (genvar i = 0; i < NP; i++) begin : g_chk
    a_single_grant: assert property (
      @(posedge clock) disable iff (reset_i) $onehot0(granted_by[i])
    ) else $error("input %0d granted by more than one output", i);
  end

endmodule

`default_nettype wire

/* noc_input_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_macros.svh"

module noc_input_buffer #(
  parameter noc_flit_pkg::coord_t ROUTER_X = '0,
  parameter noc_flit_pkg::coord_t ROUTER_Y = '0
) (
  input  wire logic                     clock,
  input  wire logic                     reset_i,
  input  wire logic                     rx_i,
  input  wire noc_flit_pkg::flit_t      data_i,
  input  wire logic                     pop_i,
  output logic                          credit_o,
  output logic                          head_valid_o,
  output noc_flit_pkg::flit_t           head_flit_o,
  output noc_port_pkg::port_mask_t      route_o
);

  localparam int DEPTH = `NOC_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  noc_flit_pkg::flit_t         mem [DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  noc_flit_pkg::credit_cnt_t   fill;
  noc_flit_pkg::coord_t        dest_x;
  noc_flit_pkg::coord_t        dest_y;

  // slot storage, written on every received flit
  always_ff @(posedge clock) begin
    if (rx_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      credit_o <= 1'b0;
    end else begin
      if (rx_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({rx_i, pop_i})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // freed slot goes back to the sender one cycle later
      credit_o <= pop_i;
    end
  end

  assign head_valid_o = (fill != '0);
  assign head_flit_o  = mem[rd_ptr];

  assign dest_x = head_flit_o[15:8];
  assign dest_y = head_flit_o[7:0];

  // XY order: settle x first, then y
  always_comb begin
    route_o = '0;
    if (dest_x > ROUTER_X) begin
      route_o[noc_port_pkg::EAST] = 1'b1;
    end else if (dest_x < ROUTER_X) begin
      route_o[noc_port_pkg::WEST] = 1'b1;
    end else if (dest_y > ROUTER_Y) begin
      route_o[noc_port_pkg::NORTH] = 1'b1;
    end else if (dest_y < ROUTER_Y) begin
      route_o[noc_port_pkg::SOUTH] = 1'b1;
    end else begin
      route_o[noc_port_pkg::LOCAL] = 1'b1;
    end
  end

  // the upstream credit counter must keep the sender off a full buffer
  a_no_write_when_full: assert property (
    @(posedge clock) disable iff (reset_i) rx_i |-> (fill != DEPTH)
  ) else $error("write into full input buffer at router (%0d,%0d)", ROUTER_X, ROUTER_Y);

endmodule

`default_nettype wire

/* noc_port_pkg.sv */
`default_nettype none

package noc_port_pkg;

  // router ports, also the index of every per-port array
  typedef enum logic [2:0] {EAST = 0, WEST = 1, NORTH = 2, SOUTH = 3, LOCAL = 4} port_e;

  localparam int NUM_PORTS = 5;

  // one bit per port_e, used for requests and grants
  typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

/* noc_flit_pkg.sv */
`default_nettype none

`include "noc_macros.svh"

package noc_flit_pkg;

  // one single-flit packet
  // payload in the upper half, destination in the lower half
  typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

  // one mesh coordinate, x at flit bits 15..8 and y at bits 7..0
  typedef logic [7:0] coord_t;

  // upper half of the flit
  typedef logic [15:0] payload_t;

  // counts 0 up to NOC_BUF_DEPTH inclusive
  typedef logic [$clog2(`NOC_BUF_DEPTH + 1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

/* noc_macros.svh */
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// width of one flit in bits
`define NOC_FLIT_WIDTH 32

// flit slots per input buffer
// also the credit count a sender starts with
`define NOC_BUF_DEPTH 4

// mesh size
`define NOC_DIM_X 2
`define NOC_DIM_Y 2

`endif
